/* src/fetch_pkg.sv */
// ----------------------------------------
// Fetch front end package. Shared word,
// bus, pipeline and control types plus the
// configuration constants of the fetch path.
// ----------------------------------------
`default_nettype none

package fetch_pkg;

  // ---------------------------------------
  // Configuration
  // ---------------------------------------
  localparam logic [31:0] RESET_PC          = 32'h200; // First fetch address out of reset.
  localparam int          BTB_ENTRIES       = 16;      // Number of predictor entries.
  localparam int          BTB_IDX_W         = 4;       // Index bits, log2 of BTB_ENTRIES.
  localparam bit          BUS_LITTLE_ENDIAN = 1'b1;    // Swap rdata bytes on the way in.

  typedef logic [31:0] word_t; // Machine word, used for both addresses and instructions.

  // ---------------------------------------
  // Instruction bus
  // ---------------------------------------
  typedef struct packed {
    word_t addr; // Word address of the fetch.
    logic  ren;  // Read enable level.
  } ibus_req_t;

  typedef struct packed {
    word_t rdata; // Instruction word from memory.
    logic  busy;  // High while rdata is not valid.
  } ibus_rsp_t;

  // Fetch to execute pipeline register.
  typedef struct packed {
    logic  token;      // Set when the slot holds a real instruction.
    word_t pc;
    word_t pc4;
    word_t instr;      // Already in processor byte order.
    logic  prediction; // Taken prediction made at fetch time.
  } fetch_ex_t;

  // Branch outcome reported by execute for one cycle.
  typedef struct packed {
    logic  valid;
    word_t pc;         // Address of the resolved branch.
    logic  taken;
    logic  prediction; // What fetch guessed for this branch.
    word_t brj_addr;   // Correct next address, target or pc+4.
  } resolve_t;

  typedef struct packed {
    logic  valid;   // One cycle pulse.
    word_t priv_pc; // Trap vector address.
  } trap_t;

  typedef struct packed {
    logic  mal_insn; // Misaligned fetch address.
    word_t badaddr;
    word_t epc;
  } fetch_fault_t;

  // Two bit saturating counter. The upper bit gives the taken prediction.
  typedef enum logic [1:0] {
    strong_nt = 2'b00,
    weak_nt   = 2'b01,
    weak_t    = 2'b10,
    strong_t  = 2'b11
  } ctr_state_t;

endpackage

`default_nettype wire

/* src/branch_predictor.sv */
// ----------------------------------------
// Branch predictor. Direct mapped target
// buffer with two bit counters, trained by
// branch resolutions from execute.
// ----------------------------------------
`default_nettype none

module branch_predictor (
  input  logic               CLK,
  input  logic               nRST,
  input  fetch_pkg::word_t   current_pc,
  input  fetch_pkg::resolve_t resolve,
  output logic               predict_taken,
  output fetch_pkg::word_t   target_addr
);
  import fetch_pkg::*;

  localparam int TAG_W = 32 - BTB_IDX_W - 2; // Address bits above index and word offset.

  // Table storage, one slot per index value.
  logic [BTB_ENTRIES-1:0] valid_q;
  logic [TAG_W-1:0]       tag_q    [BTB_ENTRIES];
  word_t                  target_q [BTB_ENTRIES];
  ctr_state_t             ctr_q    [BTB_ENTRIES];

  logic [BTB_IDX_W-1:0] rd_idx, wr_idx;
  logic [TAG_W-1:0]     rd_tag, wr_tag;
  logic                 rd_hit, wr_hit;

  // Move a counter one step toward the resolved direction.
  function automatic ctr_state_t ctr_step(input ctr_state_t cur, input logic taken);
    ctr_state_t nxt;
    case (cur)
      strong_nt: nxt = taken ? weak_nt : strong_nt;
      weak_nt:   nxt = taken ? weak_t  : strong_nt;
      weak_t:    nxt = taken ? strong_t : weak_nt;
      default:   nxt = taken ? strong_t : weak_t;
    endcase
    return nxt;
  endfunction

  // ---------------------------------------
  // Lookup
  // ---------------------------------------
  assign rd_idx = current_pc[BTB_IDX_W+1:2];      // Skip the byte offset within the word.
  assign rd_tag = current_pc[31:BTB_IDX_W+2];
  assign rd_hit = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);

  assign predict_taken = rd_hit && ctr_q[rd_idx][1]; // Upper bit set for weak_t and strong_t.
  assign target_addr   = target_q[rd_idx];

  // ---------------------------------------
  // Update from execute
  // ---------------------------------------
  assign wr_idx = resolve.pc[BTB_IDX_W+1:2];
  assign wr_tag = resolve.pc[31:BTB_IDX_W+2];
  assign wr_hit = valid_q[wr_idx] && (tag_q[wr_idx] == wr_tag);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      valid_q <= '0; // Whole table is empty after reset.
    end else if (resolve.valid && !wr_hit && resolve.taken) begin
      valid_q[wr_idx] <= 1'b1; // Taken miss claims the slot.
    end
  end

  always_ff @(posedge CLK) begin
    if (resolve.valid) begin
      if (wr_hit) begin
        ctr_q[wr_idx] <= ctr_step(ctr_q[wr_idx], resolve.taken);
        // On a not-taken outcome brj_addr is just pc+4, so keep the stored target.
        if (resolve.taken) begin
          target_q[wr_idx] <= resolve.brj_addr;
        end
      end else if (resolve.taken) begin
        tag_q[wr_idx]    <= wr_tag;
        target_q[wr_idx] <= resolve.brj_addr;
        ctr_q[wr_idx]    <= weak_t; // New entries start weakly taken.
      end
    end
  end

endmodule

`default_nettype wire

/* src/fetch_hazard_unit.sv */
// ----------------------------------------
// Fetch hazard unit. Turns memory busy,
// execute stall, mispredictions and traps
// into the enables of the fetch stage.
// ----------------------------------------
`default_nettype none

module fetch_hazard_unit (
  input  logic                ex_stall,
  input  logic                i_mem_busy,
  input  fetch_pkg::resolve_t resolve,
  input  fetch_pkg::trap_t    trap,
  output logic                pc_en,
  output logic                npc_sel,
  output logic                insert_priv_pc,
  output logic                iren,
  output logic                if_ex_stall,
  output logic                if_ex_flush,
  output fetch_pkg::word_t    priv_pc,
  output fetch_pkg::word_t    brj_addr
);

  logic mispredict;  // Execute disagrees with the fetch time guess.
  logic redirect;    // Branch redirect that is not overridden by a trap.
  logic take_trap;
  logic fetch_ok;    // A valid word can move into the pipeline register.
  logic mem_bubble;  // Memory stalled while execute is ready for more.

  // ---------------------------------------
  // Redirect sources
  // ---------------------------------------
  assign mispredict = resolve.valid && (resolve.taken != resolve.prediction);
  assign take_trap  = trap.valid;
  assign redirect   = mispredict && !take_trap; // The trap wins over a misprediction.

  // The vector and branch address pass straight to the next PC mux.
  assign priv_pc        = trap.priv_pc;
  assign brj_addr       = resolve.brj_addr;
  assign insert_priv_pc = take_trap;
  assign npc_sel        = redirect;

  // ---------------------------------------
  // Stage enables
  // ---------------------------------------
  assign fetch_ok   = !i_mem_busy && !ex_stall;
  assign mem_bubble = i_mem_busy && !ex_stall;

  // The PC moves on a redirect of either kind, or when the fetched word was accepted.
  // A busy bus holds the PC so the same address is asked for again.
  assign pc_en = take_trap || redirect || fetch_ok;

  // Wrong-path work is dropped on a redirect. A busy bus inserts a bubble with token 0.
  assign if_ex_flush = take_trap || redirect || mem_bubble;

  assign if_ex_stall = ex_stall; // Execute back-pressure freezes the register.

  assign iren = 1'b1; // Fetch always asks for the next word.

endmodule

`default_nettype wire

/* src/fetch_stage.sv */
// ----------------------------------------
// Fetch stage. PC register and next PC mux,
// instruction bus drive, byte order fix,
// fetch/execute register and fault report.
// ----------------------------------------
`default_nettype none

module fetch_stage (
  input  logic                    CLK,
  input  logic                    nRST,
  // Hazard unit controls.
  input  logic                    pc_en,
  input  logic                    npc_sel,
  input  logic                    insert_priv_pc,
  input  fetch_pkg::word_t        priv_pc,
  input  fetch_pkg::word_t        brj_addr,
  input  logic                    iren,
  input  logic                    if_ex_stall,
  input  logic                    if_ex_flush,
  output logic                    i_mem_busy,
  // Predictor.
  input  logic                    predict_taken,
  input  fetch_pkg::word_t        target_addr,
  output fetch_pkg::word_t        current_pc,
  // Instruction bus.
  output fetch_pkg::ibus_req_t    ibus_req,
  input  fetch_pkg::ibus_rsp_t    ibus_rsp,
  // Toward execute and the exception logic.
  output fetch_pkg::fetch_ex_t    fetch_ex,
  output fetch_pkg::fetch_fault_t fault
);
  import fetch_pkg::*;

  word_t pc, pc4, npc;
  word_t instr;     // Returned word in processor byte order.
  logic  mal_addr;

  // ---------------------------------------
  // Program counter
  // ---------------------------------------
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc <= RESET_PC;
    end else if (pc_en) begin
      pc <= npc;
    end
  end

  assign pc4        = pc + 32'd4;
  assign current_pc = pc; // Predictor looks up the address being fetched now.

  // Trap vector first, then the branch redirect, then the prediction, else sequential.
  always_comb begin
    if (insert_priv_pc) begin
      npc = priv_pc;
    end else if (npc_sel) begin
      npc = brj_addr;
    end else if (predict_taken) begin
      npc = target_addr;
    end else begin
      npc = pc4;
    end
  end

  // ---------------------------------------
  // Instruction bus
  // ---------------------------------------
  assign ibus_req.addr = pc;
  assign ibus_req.ren  = iren;
  assign i_mem_busy    = ibus_rsp.busy;

  // Bring the returned word into processor byte order.
  generate
    if (BUS_LITTLE_ENDIAN) begin : g_swap
      assign instr = {ibus_rsp.rdata[7:0],   ibus_rsp.rdata[15:8],
                      ibus_rsp.rdata[23:16], ibus_rsp.rdata[31:24]};
    end else begin : g_pass
      assign instr = ibus_rsp.rdata;
    end
  endgenerate

  // ---------------------------------------
  // Fetch/execute register
  // ---------------------------------------
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      fetch_ex <= '0;
    end else if (if_ex_flush) begin
      fetch_ex <= '0;                       // Bubble, token stays low.
    end else if (!if_ex_stall) begin
      fetch_ex.token      <= 1'b1;
      fetch_ex.pc         <= pc;
      fetch_ex.pc4        <= pc4;
      fetch_ex.instr      <= instr;
      fetch_ex.prediction <= predict_taken; // Execute needs this to spot a misprediction.
    end
  end

  // Misaligned fetch report, taken straight from the current PC.
  assign mal_addr       = (pc[1:0] != 2'b00);
  assign fault.mal_insn = ibus_req.ren && mal_addr;
  assign fault.badaddr  = pc;
  assign fault.epc      = pc;

endmodule

`default_nettype wire

/* src/fetch_frontend.sv */
// ----------------------------------------
// Fetch front end top. Joins the branch
// predictor, hazard unit and fetch stage.
// ----------------------------------------
`default_nettype none

module fetch_frontend (
  input  logic                    CLK,
  input  logic                    nRST,
  output fetch_pkg::ibus_req_t    ibus_req,
  input  fetch_pkg::ibus_rsp_t    ibus_rsp,
  input  logic                    ex_stall,
  input  fetch_pkg::resolve_t     resolve,
  input  fetch_pkg::trap_t        trap,
  output fetch_pkg::fetch_ex_t    fetch_ex,
  output fetch_pkg::fetch_fault_t fault
);
  import fetch_pkg::*;

  // Predictor to fetch stage.
  word_t current_pc, target_addr;
  logic  predict_taken;

  // Hazard unit to fetch stage and back.
  logic  pc_en, npc_sel, insert_priv_pc, iren;
  logic  if_ex_stall, if_ex_flush, i_mem_busy;
  word_t priv_pc, brj_addr;

  branch_predictor i_predictor (
    .CLK           (CLK),
    .nRST          (nRST),
    .current_pc    (current_pc),
    .resolve       (resolve),
    .predict_taken (predict_taken),
    .target_addr   (target_addr)
  );

  fetch_hazard_unit i_hazard (
    .ex_stall       (ex_stall),
    .i_mem_busy     (i_mem_busy),
    .resolve        (resolve),
    .trap           (trap),
    .pc_en          (pc_en),
    .npc_sel        (npc_sel),
    .insert_priv_pc (insert_priv_pc),
    .iren           (iren),
    .if_ex_stall    (if_ex_stall),
    .if_ex_flush    (if_ex_flush),
    .priv_pc        (priv_pc),
    .brj_addr       (brj_addr)
  );

  fetch_stage i_fetch (
    .CLK (CLK), .nRST (nRST),
    .pc_en (pc_en), .npc_sel (npc_sel), .insert_priv_pc (insert_priv_pc),
    .priv_pc (priv_pc), .brj_addr (brj_addr), .iren (iren),
    .if_ex_stall (if_ex_stall), .if_ex_flush (if_ex_flush), .i_mem_busy (i_mem_busy),
    .predict_taken (predict_taken), .target_addr (target_addr), .current_pc (current_pc),
    .ibus_req (ibus_req), .ibus_rsp (ibus_rsp),
    .fetch_ex (fetch_ex), .fault (fault)
  );

endmodule

`default_nettype wire

/* testbench/tb_fetch_tests.svh */
// ----------------------------------------
// Directed tests for the fetch front end.
// ----------------------------------------
`ifndef TB_FETCH_TESTS_SVH
`define TB_FETCH_TESTS_SVH

localparam word_t BR_X      = 32'h344; // Branch that the predictor learns.
localparam word_t BR_T      = 32'h400; // Its taken target.
localparam word_t BR_Z      = 32'h7f0; // Branch that loses against a trap.
localparam word_t WRONG_TGT = 32'h700;
localparam word_t TRAP_VEC  = 32'h600;
localparam word_t MIS_VEC   = 32'h682; // Low bits 2'b10.
localparam word_t ALIGN_VEC = 32'h800;

// Wait for the next edge, then step to where inputs are driven and outputs are stable.
task automatic tick();
  @(posedge CLK);
  #(DRIVE_DLY);
endtask

task automatic check_equal(input string what, input logic [127:0] got,
                           input logic [127:0] exp);
  assert (got === exp) begin
    pass_count++;
  end else begin
    fail_count++;
    $display("ERROR at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
  end
endtask

// A valid slot carries the PC, PC+4, the corrected word and the guess.
task automatic check_slot(input word_t pc, input logic pred);
  check_equal("token", fetch_ex.token, 1'b1);
  check_equal("pc", fetch_ex.pc, pc);
  check_equal("pc4", fetch_ex.pc4, pc + 32'd4);
  check_equal("instr", fetch_ex.instr, expected_instr(pc));
  check_equal("prediction", fetch_ex.prediction, pred);
endtask

task automatic check_bubble();
  check_equal("bubble token", fetch_ex.token, 1'b0);
endtask

task automatic report_test(input string name, input int errs_before);
  $display("Test %-22s %s, %0d errors", name,
           (fail_count == errs_before) ? "passed" : "failed", fail_count - errs_before);
endtask

// Plain sequential stream from the reset address.
task automatic sequential_fetch();
  int errs;
  errs = fail_count;
  check_equal("reset addr", ibus_req.addr, RESET_PC);
  check_bubble();
  check_equal("reset mal_insn", fault.mal_insn, 1'b0);
  repeat (SEQ_LEN) begin
    tick();
    check_equal("ren", ibus_req.ren, 1'b1); // Read enable stays high out of reset.
    check_slot(exp_pc, 1'b0);
    exp_pc += 32'd4;
  end
  report_test("sequential fetch", errs);
endtask

// Random busy cycles give bubbles but skip no address.
task automatic memory_wait_states();
  int          errs;
  logic [31:0] r;
  errs = fail_count;
  repeat (WAIT_LEN) begin
    r        = next_rand();
    mem_busy = r[17];
    check_equal("fetch addr", ibus_req.addr, exp_pc);
    tick();
    if (mem_busy) begin
      check_bubble();
    end else begin
      check_slot(exp_pc, 1'b0);
      exp_pc += 32'd4;
    end
  end
  mem_busy = 1'b0;
  report_test("memory wait states", errs);
endtask

// An execute stall freezes both the PC and the register.
task automatic execute_stall();
  int errs;
  errs = fail_count;
  tick();                   // One clean fetch so the register holds a known slot.
  check_slot(exp_pc, 1'b0);
  exp_pc += 32'd4;
  ex_stall = 1'b1;
  repeat (STALL_LEN) begin
    tick();
    check_slot(exp_pc - 32'd4, 1'b0);
    check_equal("stalled addr", ibus_req.addr, exp_pc);
  end
  ex_stall = 1'b0;
  tick();
  check_slot(exp_pc, 1'b0); // Fetch goes on at the held address.
  exp_pc += 32'd4;
  report_test("execute stall", errs);
endtask

// A taken miss redirects and trains the predictor. Later fetches of X follow the counter.
task automatic mispredict_and_learn();
  int errs;
  errs = fail_count;
  resolve = '{valid: 1'b1, pc: BR_X, taken: 1'b1, prediction: 1'b0, brj_addr: BR_T};
  tick();
  resolve = '0;
  check_bubble();
  check_equal("redirect addr", ibus_req.addr, BR_T);
  exp_pc = BR_T;
  repeat (3) begin
    tick();
    check_slot(exp_pc, 1'b0);
    exp_pc += 32'd4;
  end
  trap = '{valid: 1'b1, priv_pc: BR_X}; // Use a trap to come back to X.
  tick();
  trap = '0;
  check_bubble();
  tick();
  check_slot(BR_X, 1'b1);
  resolve = '{valid: 1'b1, pc: BR_X, taken: 1'b1, prediction: 1'b1, brj_addr: BR_T};
  tick();                   // Counter goes to strong taken.
  resolve = '0;
  check_slot(BR_T, 1'b0);   // Target follows X with no bubble.
  exp_pc = BR_T + 32'd4;
  repeat (2) begin
    resolve = '{valid: 1'b1, pc: BR_X, taken: 1'b0, prediction: 1'b0,
                brj_addr: BR_X + 32'd4};
    tick();
    resolve = '0;
    check_slot(exp_pc, 1'b0);
    exp_pc += 32'd4;
  end
  trap = '{valid: 1'b1, priv_pc: BR_X};
  tick();
  trap = '0;
  check_bubble();
  tick();
  check_slot(BR_X, 1'b0);   // Weakly not taken now.
  tick();
  check_slot(BR_X + 32'd4, 1'b0);
  exp_pc = BR_X + 32'd8;
  report_test("mispredict and learn", errs);
endtask

// Trap beats a misprediction, then a misaligned vector raises the fault.
task automatic trap_and_misaligned();
  int errs;
  errs = fail_count;
  resolve = '{valid: 1'b1, pc: BR_Z, taken: 1'b1, prediction: 1'b0, brj_addr: WRONG_TGT};
  trap    = '{valid: 1'b1, priv_pc: TRAP_VEC};
  tick();
  resolve = '0;
  trap    = '0;
  check_bubble();
  check_equal("trap addr", ibus_req.addr, TRAP_VEC);
  tick();
  check_slot(TRAP_VEC, 1'b0);
  trap = '{valid: 1'b1, priv_pc: MIS_VEC};
  tick();
  trap = '0;
  check_bubble();
  check_equal("mal_insn", fault.mal_insn, 1'b1);
  check_equal("badaddr", fault.badaddr, MIS_VEC);
  check_equal("epc", fault.epc, MIS_VEC);
  tick();
  check_equal("next badaddr", fault.badaddr, MIS_VEC + 32'd4);
  trap = '{valid: 1'b1, priv_pc: ALIGN_VEC};
  tick();
  trap = '0;
  check_equal("cleared mal_insn", fault.mal_insn, 1'b0);
  check_equal("aligned addr", ibus_req.addr, ALIGN_VEC);
  tick();
  check_slot(ALIGN_VEC, 1'b0);
  report_test("trap and misaligned", errs);
endtask

`endif

/* testbench/tb_fetch_frontend.sv */
// ----------------------------------------
// Fetch front end testbench. Clock, reset,
// instruction memory model, busy generator,
// watchdog and the directed test sequence.
// ----------------------------------------
`default_nettype none

module tb_fetch_frontend;
  timeunit 1ns;
  timeprecision 100ps;
  import fetch_pkg::*;

  // ---------------------------------------
  // Timing and test lengths
  // ---------------------------------------
  localparam int          CLK_PERIOD    = 40;  // Clock period in ns.
  localparam int          DRIVE_DLY     = 5;   // Input drive delay after the rising edge.
  localparam int          RESET_CYCLES  = 5;
  localparam int          SEQ_LEN       = 8;   // Cycles of plain sequential fetch.
  localparam int          WAIT_LEN      = 24;  // Cycles with random memory wait states.
  localparam int          STALL_LEN     = 4;   // Cycles with execute stalled.
  localparam int          LEARN_CYCLES  = 12;  // Length of the predictor test.
  localparam int          TRAP_CYCLES   = 6;   // Length of the trap test.
  localparam int          MARGIN_CYCLES = 20;
  localparam logic [31:0] LCG_SEED      = 32'hc455;

  // Every test adds up here, the watchdog fires well after the last one.
  localparam int TEST_CYCLES = RESET_CYCLES + SEQ_LEN + WAIT_LEN + (STALL_LEN + 2) +
                               LEARN_CYCLES + TRAP_CYCLES;
  localparam int WATCHDOG_NS = (TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;

  logic         CLK;
  logic         nRST;
  logic         mem_busy;   // Busy level of the memory model.
  logic         ex_stall;
  resolve_t     resolve;
  trap_t        trap;
  ibus_req_t    ibus_req;
  ibus_rsp_t    ibus_rsp;
  fetch_ex_t    fetch_ex;
  fetch_fault_t fault;

  logic [31:0] lcg_state;   // State of the busy pattern generator.
  word_t       exp_pc;      // Next address the fetch stage should deliver.
  int          pass_count;
  int          fail_count;

  // ---------------------------------------
  // Memory model and reference functions
  // ---------------------------------------
  // Each address gets its own word, all 32 address bits take part.
  function automatic word_t mem_word(input word_t addr);
    return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]} ^ 32'h0013_0093;
  endfunction

  // The bus delivers bytes in the reverse order when it is little endian.
  function automatic word_t expected_instr(input word_t addr);
    word_t w;
    w = mem_word(addr);
    if (BUS_LITTLE_ENDIAN) begin
      return {w[7:0], w[15:8], w[23:16], w[31:24]};
    end
    return w;
  endfunction

  // Linear congruential generator for the busy pattern.
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  assign ibus_rsp = '{rdata: mem_word(ibus_req.addr), busy: mem_busy}; // Zero-wait read.

  fetch_frontend i_dut (
    .CLK      (CLK),
    .nRST     (nRST),
    .ibus_req (ibus_req),
    .ibus_rsp (ibus_rsp),
    .ex_stall (ex_stall),
    .resolve  (resolve),
    .trap     (trap),
    .fetch_ex (fetch_ex),
    .fault    (fault)
  );

  `include "tb_fetch_tests.svh"

  // ---------------------------------------
  // Clock, watchdog and test sequence
  // ---------------------------------------
  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog timeout: the tests did not finish within %0d ns.", WATCHDOG_NS);
    $display("Something failed");
    $finish;
  end

  initial begin
    nRST       = 1'b0; // All inputs start in a known state.
    mem_busy   = 1'b0;
    ex_stall   = 1'b0;
    resolve    = '0;
    trap       = '0;
    lcg_state  = LCG_SEED;
    exp_pc     = RESET_PC;
    pass_count = 0;
    fail_count = 0;
    repeat (RESET_CYCLES) @(posedge CLK);
    #(DRIVE_DLY);
    nRST = 1'b1;

    sequential_fetch();
    memory_wait_states();
    execute_stall();
    mispredict_and_learn();
    trap_and_misaligned();

    $display("Checks passed: %0d, checks failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+testbench
src/fetch_pkg.sv
src/branch_predictor.sv
src/fetch_hazard_unit.sv
src/fetch_stage.sv
src/fetch_frontend.sv
testbench/tb_fetch_frontend.sv

/* Bender.yml */
package:
  name: fetch_frontend
  description: "Instruction fetch front end of a two-stage RV32 pipeline"

sources:
  # RTL in compile order, package first.
  - files:
      - src/fetch_pkg.sv
      - src/branch_predictor.sv
      - src/fetch_hazard_unit.sv
      - src/fetch_stage.sv
      - src/fetch_frontend.sv

  # Testbench, its test tasks are included from the testbench folder.
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_fetch_frontend.sv
